//--- design/ctrlport_pkg.sv
// ControlPort and cable register definitions
package ctrlport_pkg;

  // --------------------------------------------------
  // ControlPort field widths
  // --------------------------------------------------
  localparam int CTRLPORT_ADDR_W    = 20;
  localparam int CTRLPORT_DATA_W    = 32;
  localparam int CTRLPORT_BYTE_EN_W = 4;

  // Response status codes
  typedef enum logic [1:0] {
    CTRL_STS_OKAY    = 2'b00,
    CTRL_STS_CMDERR  = 2'b01,
    CTRL_STS_TSERR   = 2'b10,
    CTRL_STS_WARNING = 2'b11
  } ctrlport_status_t;

  // --------------------------------------------------
  // Board controller address map
  // --------------------------------------------------
  // Board controller window
  localparam logic [CTRLPORT_ADDR_W-1:0] MB_CPLD           = 20'h08000;
  // PL register block inside the board controller
  localparam logic [CTRLPORT_ADDR_W-1:0] PL_REGISTERS      = 20'h00400;
  // Cable present register offset
  localparam logic [CTRLPORT_ADDR_W-1:0] CABLE_PRESENT_REG = 20'h00040;

  // Full address seen on the bus
  localparam logic [CTRLPORT_ADDR_W-1:0] CABLE_PRESENT_ADDR =
    MB_CPLD + PL_REGISTERS + CABLE_PRESENT_REG;

  // Bit positions in register data
  localparam int IPASS0_CABLE_PRESENT = 0;
  localparam int IPASS1_CABLE_PRESENT = 1;

  // Number of iPass cable ports
  localparam int NUM_IPASS = 2;

endpackage

//--- design/bit_synchronizer.sv
// Flip-flop level synchronizer
`timescale 1ns/1ps

module bit_synchronizer #(
  parameter int WIDTH       = 1,
  parameter int SYNC_STAGES = 2
) (
  input  logic             ctrlport_clk,
  input  logic             ctrlport_rst,
  input  logic [WIDTH-1:0] async_in,
  output logic [WIDTH-1:0] sync_out
);

  // Stage 0 samples the asynchronous pins
  logic [WIDTH-1:0] sync_q [SYNC_STAGES];

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= async_in;
      // Shift along the chain
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // Last stage is the settled value
  assign sync_out = sync_q[SYNC_STAGES-1];

endmodule

//--- design/ipass_present_controller.sv
// iPass cable present write producer
`timescale 1ns/1ps

module ipass_present_controller #(
  parameter int SYNC_STAGES = 2
) (
  input  logic ctrlport_clk,
  input  logic ctrlport_rst,

  // Configuration
  input  logic enable,

  // Active low asynchronous pins
  input  logic [ctrlport_pkg::NUM_IPASS-1:0] ipass_present_n,

  // ControlPort request
  output logic                                     m_ctrlport_req_wr,
  output logic                                     m_ctrlport_req_rd,
  output logic [ctrlport_pkg::CTRLPORT_ADDR_W-1:0] m_ctrlport_req_addr,
  output logic [ctrlport_pkg::CTRLPORT_DATA_W-1:0] m_ctrlport_req_data,
  output logic [ctrlport_pkg::CTRLPORT_BYTE_EN_W-1:0] m_ctrlport_req_byte_en,

  // ControlPort response
  input  logic                                     m_ctrlport_resp_ack,
  input  ctrlport_pkg::ctrlport_status_t           m_ctrlport_resp_status,
  input  logic [ctrlport_pkg::CTRLPORT_DATA_W-1:0] m_ctrlport_resp_data
);

  import ctrlport_pkg::*;

  // --------------------------------------------------
  // Pin synchronization
  // --------------------------------------------------
  logic [NUM_IPASS-1:0] present_sync;

  bit_synchronizer #(
    .WIDTH       (NUM_IPASS),
    .SYNC_STAGES (SYNC_STAGES)
  ) present_sync_i (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .async_in     (~ipass_present_n),
    .sync_out     (present_sync)
  );

  // --------------------------------------------------
  // Change detection and request issue
  // --------------------------------------------------
  logic                 in_progress;
  logic                 error_seen;
  logic                 enable_q;
  logic [NUM_IPASS-1:0] present_cached;

  // Enable rising edge forces a resend
  logic activated;
  assign activated = enable & ~enable_q;

  logic need_write;
  assign need_write = (present_sync != present_cached) || error_seen || activated;

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      m_ctrlport_req_wr <= 1'b0;
      in_progress       <= 1'b0;
      error_seen        <= 1'b0;
      enable_q          <= 1'b0;
      present_cached    <= '0;
    end else begin
      m_ctrlport_req_wr <= 1'b0;
      enable_q          <= enable;

      // One write at a time
      if (need_write && !in_progress && enable) begin
        m_ctrlport_req_wr <= 1'b1;
        in_progress       <= 1'b1;
        present_cached    <= present_sync;
      end

      // Ack closes the transfer and an error arms a retry
      if (m_ctrlport_resp_ack) begin
        in_progress <= 1'b0;
        error_seen  <= (m_ctrlport_resp_status != CTRL_STS_OKAY);
      end
    end
  end

  // --------------------------------------------------
  // Fixed request fields
  // --------------------------------------------------
  assign m_ctrlport_req_rd      = 1'b0;
  assign m_ctrlport_req_addr    = CABLE_PRESENT_ADDR;
  assign m_ctrlport_req_byte_en = '1;

  always_comb begin
    m_ctrlport_req_data                       = '0;
    m_ctrlport_req_data[IPASS0_CABLE_PRESENT] = present_cached[0];
    m_ctrlport_req_data[IPASS1_CABLE_PRESENT] = present_cached[1];
  end

endmodule

//--- design/ctrlport_req_buffer.sv
// ControlPort request queue
`timescale 1ns/1ps

module ctrlport_req_buffer #(
  parameter int BUFFER_DEPTH = 4
) (
  input  logic ctrlport_clk,
  input  logic ctrlport_rst,

  // Upstream request
  input  logic                                     s_ctrlport_req_wr,
  input  logic                                     s_ctrlport_req_rd,
  input  logic [ctrlport_pkg::CTRLPORT_ADDR_W-1:0] s_ctrlport_req_addr,
  input  logic [ctrlport_pkg::CTRLPORT_DATA_W-1:0] s_ctrlport_req_data,
  input  logic [ctrlport_pkg::CTRLPORT_BYTE_EN_W-1:0] s_ctrlport_req_byte_en,

  // Upstream response
  output logic                                     s_ctrlport_resp_ack,
  output ctrlport_pkg::ctrlport_status_t           s_ctrlport_resp_status,
  output logic [ctrlport_pkg::CTRLPORT_DATA_W-1:0] s_ctrlport_resp_data,

  // Downstream request
  output logic                                     m_ctrlport_req_wr,
  output logic                                     m_ctrlport_req_rd,
  output logic [ctrlport_pkg::CTRLPORT_ADDR_W-1:0] m_ctrlport_req_addr,
  output logic [ctrlport_pkg::CTRLPORT_DATA_W-1:0] m_ctrlport_req_data,
  output logic [ctrlport_pkg::CTRLPORT_BYTE_EN_W-1:0] m_ctrlport_req_byte_en,

  // Downstream response
  input  logic                                     m_ctrlport_resp_ack,
  input  ctrlport_pkg::ctrlport_status_t           m_ctrlport_resp_status,
  input  logic [ctrlport_pkg::CTRLPORT_DATA_W-1:0] m_ctrlport_resp_data
);

  import ctrlport_pkg::*;

  localparam int PTR_W = $clog2(BUFFER_DEPTH);

  // --------------------------------------------------
  // Queue storage
  // --------------------------------------------------
  logic [CTRLPORT_ADDR_W-1:0]    addr_mem [BUFFER_DEPTH];
  logic [CTRLPORT_DATA_W-1:0]    data_mem [BUFFER_DEPTH];
  logic [CTRLPORT_BYTE_EN_W-1:0] be_mem   [BUFFER_DEPTH];
  logic                          rd_mem   [BUFFER_DEPTH];

  // Extra MSB tells full from empty
  logic [PTR_W:0] wr_ptr;
  logic [PTR_W:0] rd_ptr;
  logic           outstanding;
  logic [7:0]     drop_count;

  logic empty;
  logic full;
  logic strobe;
  logic push;
  logic issue;

  assign empty  = (wr_ptr == rd_ptr);
  assign full   = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                  (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
  assign strobe = s_ctrlport_req_wr | s_ctrlport_req_rd;
  assign push   = strobe && !full;
  // Head goes out only when downstream is idle
  assign issue  = !empty && !outstanding;

  // Payload storage write
  always_ff @(posedge ctrlport_clk) begin
    if (push) begin
      addr_mem[wr_ptr[PTR_W-1:0]] <= s_ctrlport_req_addr;
      data_mem[wr_ptr[PTR_W-1:0]] <= s_ctrlport_req_data;
      be_mem[wr_ptr[PTR_W-1:0]]   <= s_ctrlport_req_byte_en;
      rd_mem[wr_ptr[PTR_W-1:0]]   <= s_ctrlport_req_rd;
    end
  end

  // --------------------------------------------------
  // Pointers and outstanding tracking
  // --------------------------------------------------
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      outstanding <= 1'b0;
      drop_count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      // Full queue loses the request and counts the drop
      if (strobe && full) begin
        drop_count <= drop_count + 1'b1;
      end
      if (issue) begin
        rd_ptr      <= rd_ptr + 1'b1;
        outstanding <= 1'b1;
      end else if (m_ctrlport_resp_ack) begin
        outstanding <= 1'b0;
      end
    end
  end

  // Head entry drives the downstream port
  assign m_ctrlport_req_wr      = issue && !rd_mem[rd_ptr[PTR_W-1:0]];
  assign m_ctrlport_req_rd      = issue && rd_mem[rd_ptr[PTR_W-1:0]];
  assign m_ctrlport_req_addr    = addr_mem[rd_ptr[PTR_W-1:0]];
  assign m_ctrlport_req_data    = data_mem[rd_ptr[PTR_W-1:0]];
  assign m_ctrlport_req_byte_en = be_mem[rd_ptr[PTR_W-1:0]];

  // Response relayed in the same cycle
  assign s_ctrlport_resp_ack    = m_ctrlport_resp_ack;
  assign s_ctrlport_resp_status = m_ctrlport_resp_status;
  assign s_ctrlport_resp_data   = m_ctrlport_resp_data;

endmodule

//--- design/cpld_cable_register.sv
// Board controller cable present register
`timescale 1ns/1ps

module cpld_cable_register #(
  parameter int ACK_LATENCY = 3
) (
  input  logic ctrlport_clk,
  input  logic ctrlport_rst,

  // Target refuses writes while high
  input  logic cpld_reject,

  // ControlPort request
  input  logic                                     s_ctrlport_req_wr,
  input  logic                                     s_ctrlport_req_rd,
  input  logic [ctrlport_pkg::CTRLPORT_ADDR_W-1:0] s_ctrlport_req_addr,
  input  logic [ctrlport_pkg::CTRLPORT_DATA_W-1:0] s_ctrlport_req_data,
  input  logic [ctrlport_pkg::CTRLPORT_BYTE_EN_W-1:0] s_ctrlport_req_byte_en,

  // ControlPort response
  output logic                                     s_ctrlport_resp_ack,
  output ctrlport_pkg::ctrlport_status_t           s_ctrlport_resp_status,
  output logic [ctrlport_pkg::CTRLPORT_DATA_W-1:0] s_ctrlport_resp_data,

  // Register contents
  output logic [ctrlport_pkg::NUM_IPASS-1:0] cable_present,
  output logic [15:0]                        write_count
);

  import ctrlport_pkg::*;

  localparam int CNT_W = $clog2(ACK_LATENCY + 1);

  // --------------------------------------------------
  // Decode at the request pulse
  // --------------------------------------------------
  logic                 req_strobe;
  ctrlport_status_t     req_status;
  logic [NUM_IPASS-1:0] req_bits;

  assign req_strobe = s_ctrlport_req_wr | s_ctrlport_req_rd;

  always_comb begin
    req_bits = cable_present;
    if (s_ctrlport_req_addr != CABLE_PRESENT_ADDR) begin
      req_status = CTRL_STS_CMDERR;
    end else if (cpld_reject) begin
      // Register keeps its value
      req_status = CTRL_STS_TSERR;
    end else begin
      req_status = CTRL_STS_OKAY;
      // Both bits live in byte 0
      if (s_ctrlport_req_wr && s_ctrlport_req_byte_en[0]) begin
        req_bits[0] = s_ctrlport_req_data[IPASS0_CABLE_PRESENT];
        req_bits[1] = s_ctrlport_req_data[IPASS1_CABLE_PRESENT];
      end
    end
  end

  // Decision held until the ack
  ctrlport_status_t     pend_status;
  logic [NUM_IPASS-1:0] pend_bits;
  logic                 pend_wr;
  logic [CNT_W-1:0]     lat_cnt;

  always_ff @(posedge ctrlport_clk) begin
    if (req_strobe) begin
      pend_status <= req_status;
      pend_bits   <= req_bits;
      pend_wr     <= s_ctrlport_req_wr;
    end
  end

  // --------------------------------------------------
  // Latency counter and ack
  // --------------------------------------------------
  ctrlport_status_t     cur_status;
  logic [NUM_IPASS-1:0] cur_bits;
  logic                 cur_wr;
  logic                 fire;

  // Latency of one acks straight from the pulse
  assign fire       = req_strobe ? (ACK_LATENCY == 1) : (lat_cnt == CNT_W'(1));
  assign cur_status = req_strobe ? req_status : pend_status;
  assign cur_bits   = req_strobe ? req_bits : pend_bits;
  assign cur_wr     = req_strobe ? s_ctrlport_req_wr : pend_wr;

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      lat_cnt             <= '0;
      s_ctrlport_resp_ack <= 1'b0;
      cable_present       <= '0;
      write_count         <= '0;
    end else begin
      s_ctrlport_resp_ack <= 1'b0;
      if (req_strobe) begin
        lat_cnt <= CNT_W'(ACK_LATENCY - 1);
      end else if (lat_cnt != '0) begin
        lat_cnt <= lat_cnt - 1'b1;
      end
      if (fire) begin
        s_ctrlport_resp_ack <= 1'b1;
        // Only accepted writes touch the register
        if (cur_wr && cur_status == CTRL_STS_OKAY) begin
          cable_present <= cur_bits;
          write_count   <= write_count + 1'b1;
        end
      end
    end
  end

  // Response payload carries the register readback
  always_ff @(posedge ctrlport_clk) begin
    if (fire) begin
      s_ctrlport_resp_status                       <= cur_status;
      s_ctrlport_resp_data                         <= '0;
      s_ctrlport_resp_data[IPASS0_CABLE_PRESENT]   <= cur_bits[0];
      s_ctrlport_resp_data[IPASS1_CABLE_PRESENT]   <= cur_bits[1];
    end
  end

endmodule

//--- design/ipass_cable_sync_top.sv
// iPass cable present sync subsystem
`timescale 1ns/1ps

module ipass_cable_sync_top #(
  parameter int SYNC_STAGES  = 2,
  parameter int BUFFER_DEPTH = 4,
  parameter int ACK_LATENCY  = 3
) (
  input  logic                               ctrlport_clk,
  input  logic                               ctrlport_rst,
  input  logic                               enable,
  input  logic [ctrlport_pkg::NUM_IPASS-1:0] ipass_present_n,
  input  logic                               cpld_reject,
  output logic [ctrlport_pkg::NUM_IPASS-1:0] cable_present,
  output logic [15:0]                        write_count
);

  import ctrlport_pkg::*;

  // --------------------------------------------------
  // Link 1, producer to buffer
  // --------------------------------------------------
  logic                          l1_req_wr;
  logic                          l1_req_rd;
  logic [CTRLPORT_ADDR_W-1:0]    l1_req_addr;
  logic [CTRLPORT_DATA_W-1:0]    l1_req_data;
  logic [CTRLPORT_BYTE_EN_W-1:0] l1_req_byte_en;
  logic                          l1_resp_ack;
  ctrlport_status_t              l1_resp_status;
  logic [CTRLPORT_DATA_W-1:0]    l1_resp_data;

  // Link 2, buffer to register
  logic                          l2_req_wr;
  logic                          l2_req_rd;
  logic [CTRLPORT_ADDR_W-1:0]    l2_req_addr;
  logic [CTRLPORT_DATA_W-1:0]    l2_req_data;
  logic [CTRLPORT_BYTE_EN_W-1:0] l2_req_byte_en;
  logic                          l2_resp_ack;
  ctrlport_status_t              l2_resp_status;
  logic [CTRLPORT_DATA_W-1:0]    l2_resp_data;

  ipass_present_controller #(
    .SYNC_STAGES (SYNC_STAGES)
  ) ipass_present_controller_i (
    .ctrlport_clk           (ctrlport_clk),
    .ctrlport_rst           (ctrlport_rst),
    .enable                 (enable),
    .ipass_present_n        (ipass_present_n),
    .m_ctrlport_req_wr      (l1_req_wr),
    .m_ctrlport_req_rd      (l1_req_rd),
    .m_ctrlport_req_addr    (l1_req_addr),
    .m_ctrlport_req_data    (l1_req_data),
    .m_ctrlport_req_byte_en (l1_req_byte_en),
    .m_ctrlport_resp_ack    (l1_resp_ack),
    .m_ctrlport_resp_status (l1_resp_status),
    .m_ctrlport_resp_data   (l1_resp_data)
  );

  ctrlport_req_buffer #(
    .BUFFER_DEPTH (BUFFER_DEPTH)
  ) ctrlport_req_buffer_i (
    .ctrlport_clk           (ctrlport_clk),
    .ctrlport_rst           (ctrlport_rst),
    .s_ctrlport_req_wr      (l1_req_wr),
    .s_ctrlport_req_rd      (l1_req_rd),
    .s_ctrlport_req_addr    (l1_req_addr),
    .s_ctrlport_req_data    (l1_req_data),
    .s_ctrlport_req_byte_en (l1_req_byte_en),
    .s_ctrlport_resp_ack    (l1_resp_ack),
    .s_ctrlport_resp_status (l1_resp_status),
    .s_ctrlport_resp_data   (l1_resp_data),
    .m_ctrlport_req_wr      (l2_req_wr),
    .m_ctrlport_req_rd      (l2_req_rd),
    .m_ctrlport_req_addr    (l2_req_addr),
    .m_ctrlport_req_data    (l2_req_data),
    .m_ctrlport_req_byte_en (l2_req_byte_en),
    .m_ctrlport_resp_ack    (l2_resp_ack),
    .m_ctrlport_resp_status (l2_resp_status),
    .m_ctrlport_resp_data   (l2_resp_data)
  );

  cpld_cable_register #(
    .ACK_LATENCY (ACK_LATENCY)
  ) cpld_cable_register_i (
    .ctrlport_clk           (ctrlport_clk),
    .ctrlport_rst           (ctrlport_rst),
    .cpld_reject            (cpld_reject),
    .s_ctrlport_req_wr      (l2_req_wr),
    .s_ctrlport_req_rd      (l2_req_rd),
    .s_ctrlport_req_addr    (l2_req_addr),
    .s_ctrlport_req_data    (l2_req_data),
    .s_ctrlport_req_byte_en (l2_req_byte_en),
    .s_ctrlport_resp_ack    (l2_resp_ack),
    .s_ctrlport_resp_status (l2_resp_status),
    .s_ctrlport_resp_data   (l2_resp_data),
    .cable_present          (cable_present),
    .write_count            (write_count)
  );

endmodule

//--- bench/tb_stimulus_table.svh
// Testbench stimulus table
`ifndef TB_STIMULUS_TABLE_SVH
`define TB_STIMULUS_TABLE_SVH

// One step with inputs, hold, expected register and write increase
typedef struct packed {
  logic                 enable;
  logic [NUM_IPASS-1:0] present_n;
  logic                 reject;
  logic [7:0]           hold;
  logic [NUM_IPASS-1:0] exp_present;
  logic [7:0]           exp_inc;
  logic                 check;
} stim_row_t;

localparam int NUM_ROWS = 16;

stim_row_t stim_table [NUM_ROWS];

function automatic stim_row_t make_row(
  input logic                 en,
  input logic [NUM_IPASS-1:0] pins_n,
  input logic                 rej,
  input int                   hold,
  input logic [NUM_IPASS-1:0] exp_present,
  input int                   exp_inc,
  input logic                 check
);
  stim_row_t row;
  row.enable      = en;
  row.present_n   = pins_n;
  row.reject      = rej;
  row.hold        = 8'(hold);
  row.exp_present = exp_present;
  row.exp_inc     = 8'(exp_inc);
  row.check       = check;
  return row;
endfunction

// Pins are active low, so register value is the inverted pins
task automatic load_stimulus_table;
  // Reset state, then enable rise with no cable
  stim_table[0]  = make_row(1'b0, 2'b11, 1'b0, 10, 2'b00, 0, 1'b1);
  stim_table[1]  = make_row(1'b1, 2'b11, 1'b0, 12, 2'b00, 1, 1'b1);
  // Single changes within the latency bound
  stim_table[2]  = make_row(1'b1, 2'b10, 1'b0, 4 + ACK_LATENCY, 2'b01, 1, 1'b1);
  stim_table[3]  = make_row(1'b1, 2'b00, 1'b0, 4 + ACK_LATENCY, 2'b11, 1, 1'b1);
  stim_table[4]  = make_row(1'b1, 2'b01, 1'b0, 4 + ACK_LATENCY, 2'b10, 1, 1'b1);
  // Pins move while disabled and the register holds
  stim_table[5]  = make_row(1'b0, 2'b01, 1'b0, 6, 2'b10, 0, 1'b1);
  stim_table[6]  = make_row(1'b0, 2'b11, 1'b0, 12, 2'b10, 0, 1'b1);
  stim_table[7]  = make_row(1'b0, 2'b10, 1'b0, 12, 2'b10, 0, 1'b1);
  // Enable rise catches up in one write
  stim_table[8]  = make_row(1'b1, 2'b10, 1'b0, 12, 2'b01, 1, 1'b1);
  // Retries never land while the target rejects
  stim_table[9]  = make_row(1'b1, 2'b10, 1'b1, 6, 2'b01, 0, 1'b1);
  stim_table[10] = make_row(1'b1, 2'b11, 1'b1, 30, 2'b01, 0, 1'b1);
  stim_table[11] = make_row(1'b1, 2'b11, 1'b0, 16, 2'b00, 1, 1'b1);
  // Burst inside one transfer
  // First write carries an early value and one follow-up carries the last
  stim_table[12] = make_row(1'b1, 2'b10, 1'b0, 1, 2'b00, 0, 1'b0);
  stim_table[13] = make_row(1'b1, 2'b01, 1'b0, 1, 2'b00, 0, 1'b0);
  stim_table[14] = make_row(1'b1, 2'b00, 1'b0, 20, 2'b11, 2, 1'b1);
  stim_table[15] = make_row(1'b1, 2'b11, 1'b0, 12, 2'b00, 1, 1'b1);
endtask

`endif

//--- bench/tb_ipass_cable_sync.sv
// iPass cable sync testbench
`timescale 1ns/1ps

module tb_ipass_cable_sync;

  import ctrlport_pkg::*;

  localparam int SYNC_STAGES  = 2;
  localparam int BUFFER_DEPTH = 4;
  localparam int ACK_LATENCY  = 3;
  localparam int RESET_CYCLES = 5;
  // Longest random idle gap after a checked row
  localparam int MAX_GAP      = 3;

  `include "tb_stimulus_table.svh"

  // --------------------------------------------------
  // DUT signals
  // --------------------------------------------------
  logic                 ctrlport_clk;
  logic                 ctrlport_rst;
  logic                 enable;
  logic [NUM_IPASS-1:0] ipass_present_n;
  logic                 cpld_reject;
  logic [NUM_IPASS-1:0] cable_present;
  logic [15:0]          write_count;

  // Bookkeeping
  int          present_errors;
  int          count_errors;
  int          cycle_count;
  int          timeout_limit;
  logic [15:0] exp_total;

  ipass_cable_sync_top #(
    .SYNC_STAGES  (SYNC_STAGES),
    .BUFFER_DEPTH (BUFFER_DEPTH),
    .ACK_LATENCY  (ACK_LATENCY)
  ) ipass_cable_sync_top_i (
    .ctrlport_clk    (ctrlport_clk),
    .ctrlport_rst    (ctrlport_rst),
    .enable          (enable),
    .ipass_present_n (ipass_present_n),
    .cpld_reject     (cpld_reject),
    .cable_present   (cable_present),
    .write_count     (write_count)
  );

  // 40 ns period
  always #20 ctrlport_clk = ~ctrlport_clk;

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic check_present(
    input logic [NUM_IPASS-1:0] actual,
    input logic [NUM_IPASS-1:0] expected,
    input int                   row
  );
    if (actual !== expected) begin
      present_errors++;
      $display("FAILED %0t: row %0d cable_present %b, expected %b",
               $time, row, actual, expected);
    end
  endtask

  task automatic check_count(
    input logic [15:0] actual,
    input logic [15:0] expected,
    input int          row
  );
    if (actual !== expected) begin
      count_errors++;
      $display("FAILED %0t: row %0d write_count %0d, expected %0d",
               $time, row, actual, expected);
    end
  endtask

  // Whole run length in cycles with margin
  function automatic int total_test_cycles();
    int total;
    total = RESET_CYCLES + 100;
    for (int i = 0; i < NUM_ROWS; i++) begin
      // Drive edge, hold and worst gap
      total += int'(stim_table[i].hold) + 1 + MAX_GAP;
    end
    return total;
  endfunction

  // --------------------------------------------------
  // Timeout watchdog
  // --------------------------------------------------
  always @(posedge ctrlport_clk) begin
    cycle_count <= cycle_count + 1;
    if (timeout_limit != 0 && cycle_count >= timeout_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
      $display("Done: errors found");
      $finish;
    end
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    // Idle pins, no cable, target accepting
    ctrlport_clk    = 1'b0;
    ctrlport_rst    = 1'b1;
    enable          = 1'b0;
    ipass_present_n = '1;
    cpld_reject     = 1'b0;
    present_errors  = 0;
    count_errors    = 0;
    cycle_count     = 0;
    exp_total       = '0;
    void'($urandom(64172));

    load_stimulus_table();
    timeout_limit = total_test_cycles();

    repeat (RESET_CYCLES) @(posedge ctrlport_clk);
    ctrlport_rst <= 1'b0;

    for (int i = 0; i < NUM_ROWS; i++) begin
      @(posedge ctrlport_clk);
      enable          <= stim_table[i].enable;
      ipass_present_n <= stim_table[i].present_n;
      cpld_reject     <= stim_table[i].reject;
      exp_total = exp_total + 16'(stim_table[i].exp_inc);
      repeat (int'(stim_table[i].hold)) @(posedge ctrlport_clk);
      if (stim_table[i].check) begin
        // Sample away from the driving edge
        @(negedge ctrlport_clk);
        check_present(cable_present, stim_table[i].exp_present, i);
        check_count(write_count, exp_total, i);
        // Random idle gap once the row has settled
        repeat ($urandom_range(0, MAX_GAP)) @(posedge ctrlport_clk);
      end
    end

    $display("Errors: cable_present %0d, write_count %0d", present_errors, count_errors);
    if (present_errors + count_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+bench
design/ctrlport_pkg.sv
design/bit_synchronizer.sv
design/ipass_present_controller.sv
design/ctrlport_req_buffer.sv
design/cpld_cable_register.sv
design/ipass_cable_sync_top.sv
bench/tb_ipass_cable_sync.sv

//--- Bender.yml
package:
  name: ipass_cable_sync

sources:
  - files:
      - design/ctrlport_pkg.sv
      - design/bit_synchronizer.sv
      - design/ipass_present_controller.sv
      - design/ctrlport_req_buffer.sv
      - design/cpld_cable_register.sv
      - design/ipass_cable_sync_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_ipass_cable_sync.sv
